/* hw/udp_tx_pkg.sv */
package udp_tx_pkg;

	// --------------------------------------------------
	// Field types
	// --------------------------------------------------

	// One GMII byte
	typedef logic [7:0] byte_t;

	// Lengths, ports, checksum, EtherType
	typedef logic [15:0] word16_t;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [31:0] crc_t;

	// FIFO word, high byte goes out first
	typedef logic [15:0] pixel_word_t;

	// FIFO words per packet
	typedef logic [10:0] payload_len_t;

	// Header byte position 0..42
	typedef logic [5:0] hdr_idx_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_SFD,
		ST_HEADER,
		ST_PAYLOAD,
		ST_FCS,
		ST_GAP
	} tx_state_e;

	// --------------------------------------------------
	// Protocol constants
	// --------------------------------------------------

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hD5;
	localparam int    PREAMBLE_LEN  = 7;

	localparam word16_t ETH_TYPE_IPV4 = 16'h0800;

	// Version 4, IHL 5, TOS 0
	localparam word16_t IP_VER_TOS   = 16'h4500;
	// Don't fragment
	localparam word16_t IP_FLAGS     = 16'h4000;
	localparam byte_t   IP_TTL       = 8'h40;
	localparam byte_t   IP_PROTO_UDP = 8'h11;

	localparam int IP_HDR_LEN  = 20;
	localparam int UDP_HDR_LEN = 8;

	localparam byte_t PKT_TYPE_VIDEO = 8'h00;

	// Ethernet 14 + IP 20 + UDP 8 + packet type 1
	localparam int HDR_LEN = 43;

endpackage

/* hw/ipv4_checksum.sv */
module ipv4_checksum #(
	parameter udp_tx_pkg::ip_addr_t SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter udp_tx_pkg::ip_addr_t DST_IP = {8'd192, 8'd168, 8'd0, 8'd2}
) (
	input  logic                fifo_clk,
	input  logic                sys_rst,
	input  logic                frame_start,
	input  udp_tx_pkg::word16_t ip_total_len,
	output udp_tx_pkg::word16_t ip_checksum
);

	logic [19:0]         hdr_sum;
	logic [16:0]         fold_once;
	udp_tx_pkg::word16_t fold_twice;

	// Identification and checksum field are zero and drop out of the sum
	always_comb begin
		hdr_sum = {4'd0, udp_tx_pkg::IP_VER_TOS}
			+ {4'd0, ip_total_len}
			+ {4'd0, udp_tx_pkg::IP_FLAGS}
			+ {4'd0, udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP}
			+ {4'd0, SRC_IP[31:16]}
			+ {4'd0, SRC_IP[15:0]}
			+ {4'd0, DST_IP[31:16]}
			+ {4'd0, DST_IP[15:0]};
	end

	// End-around carry, the second fold catches a carry out of the first
	always_comb begin
		fold_once  = {1'b0, hdr_sum[15:0]} + {13'd0, hdr_sum[19:16]};
		fold_twice = fold_once[15:0] + {15'd0, fold_once[16]};
	end

	// Held for the whole frame, header bytes read it much later
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			ip_checksum <= '0;
		end else if (frame_start) begin
			ip_checksum <= ~fold_twice;
		end
	end

endmodule

/* hw/eth_crc32.sv */
module eth_crc32 (
	input  logic              fifo_clk,
	input  logic              sys_rst,
	input  logic              crc_init,
	input  logic              crc_en,
	input  udp_tx_pkg::byte_t crc_byte,
	input  logic [1:0]        fcs_idx,
	output udp_tx_pkg::byte_t fcs_byte
);

	// Reflected form of 0x04C11DB7
	localparam udp_tx_pkg::crc_t CRC_POLY = 32'hEDB88320;

	udp_tx_pkg::crc_t crc_q;
	udp_tx_pkg::crc_t fcs_word;

	// One byte, LSB first as it goes out on the wire
	function automatic udp_tx_pkg::crc_t crc_step(
		input udp_tx_pkg::crc_t  crc,
		input udp_tx_pkg::byte_t data
	);
		udp_tx_pkg::crc_t c;
		int               i;
		c = crc ^ {24'd0, data};
		for (i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= '1;
		end else if (crc_init) begin
			crc_q <= '1;
		end else if (crc_en) begin
			crc_q <= crc_step(crc_q, crc_byte);
		end
	end

	// FCS is the complement, least significant byte first
	assign fcs_word = ~crc_q;
	assign fcs_byte = fcs_word[{fcs_idx, 3'b000} +: 8];

	// Init happens on the SFD byte, never while data is folded in
	a_init_not_with_en: assert property (
		@(posedge fifo_clk) disable iff (sys_rst)
		!(crc_init && crc_en)
	);

endmodule

/* hw/udp_header_gen.sv */
module udp_header_gen #(
	parameter udp_tx_pkg::mac_addr_t SRC_MAC      = 48'h00_23_45_67_89_01,
	parameter udp_tx_pkg::mac_addr_t DST_MAC      = 48'h00_23_45_67_89_02,
	parameter udp_tx_pkg::ip_addr_t  SRC_IP       = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter udp_tx_pkg::ip_addr_t  DST_IP       = {8'd192, 8'd168, 8'd0, 8'd2},
	parameter udp_tx_pkg::word16_t   UDP_SRC_PORT = 16'd12344,
	parameter udp_tx_pkg::word16_t   UDP_DST_PORT = 16'd12345
) (
	input  udp_tx_pkg::hdr_idx_t hdr_idx,
	input  udp_tx_pkg::word16_t  ip_total_len,
	input  udp_tx_pkg::word16_t  udp_len,
	input  udp_tx_pkg::word16_t  ip_checksum,
	output udp_tx_pkg::byte_t    hdr_byte
);

	// All fields go out in network order, MSB byte first
	always_comb begin
		case (hdr_idx)
			// --------------------------------------------------
			// Ethernet header
			// --------------------------------------------------
			6'd0:  hdr_byte = DST_MAC[47:40];
			6'd1:  hdr_byte = DST_MAC[39:32];
			6'd2:  hdr_byte = DST_MAC[31:24];
			6'd3:  hdr_byte = DST_MAC[23:16];
			6'd4:  hdr_byte = DST_MAC[15:8];
			6'd5:  hdr_byte = DST_MAC[7:0];
			6'd6:  hdr_byte = SRC_MAC[47:40];
			6'd7:  hdr_byte = SRC_MAC[39:32];
			6'd8:  hdr_byte = SRC_MAC[31:24];
			6'd9:  hdr_byte = SRC_MAC[23:16];
			6'd10: hdr_byte = SRC_MAC[15:8];
			6'd11: hdr_byte = SRC_MAC[7:0];
			6'd12: hdr_byte = udp_tx_pkg::ETH_TYPE_IPV4[15:8];
			6'd13: hdr_byte = udp_tx_pkg::ETH_TYPE_IPV4[7:0];
			// --------------------------------------------------
			// IPv4 header
			// --------------------------------------------------
			6'd14: hdr_byte = udp_tx_pkg::IP_VER_TOS[15:8];
			6'd15: hdr_byte = udp_tx_pkg::IP_VER_TOS[7:0];
			6'd16: hdr_byte = ip_total_len[15:8];
			6'd17: hdr_byte = ip_total_len[7:0];
			// Identification is always zero
			6'd18: hdr_byte = 8'h00;
			6'd19: hdr_byte = 8'h00;
			6'd20: hdr_byte = udp_tx_pkg::IP_FLAGS[15:8];
			6'd21: hdr_byte = udp_tx_pkg::IP_FLAGS[7:0];
			6'd22: hdr_byte = udp_tx_pkg::IP_TTL;
			6'd23: hdr_byte = udp_tx_pkg::IP_PROTO_UDP;
			6'd24: hdr_byte = ip_checksum[15:8];
			6'd25: hdr_byte = ip_checksum[7:0];
			6'd26: hdr_byte = SRC_IP[31:24];
			6'd27: hdr_byte = SRC_IP[23:16];
			6'd28: hdr_byte = SRC_IP[15:8];
			6'd29: hdr_byte = SRC_IP[7:0];
			6'd30: hdr_byte = DST_IP[31:24];
			6'd31: hdr_byte = DST_IP[23:16];
			6'd32: hdr_byte = DST_IP[15:8];
			6'd33: hdr_byte = DST_IP[7:0];
			// --------------------------------------------------
			// UDP header and packet type
			// --------------------------------------------------
			6'd34: hdr_byte = UDP_SRC_PORT[15:8];
			6'd35: hdr_byte = UDP_SRC_PORT[7:0];
			6'd36: hdr_byte = UDP_DST_PORT[15:8];
			6'd37: hdr_byte = UDP_DST_PORT[7:0];
			6'd38: hdr_byte = udp_len[15:8];
			6'd39: hdr_byte = udp_len[7:0];
			// UDP checksum unused
			6'd40: hdr_byte = 8'h00;
			6'd41: hdr_byte = 8'h00;
			6'd42: hdr_byte = udp_tx_pkg::PKT_TYPE_VIDEO;
			default: hdr_byte = 8'h00;
		endcase
	end

endmodule

/* hw/gmii_frame_seq.sv */
module gmii_frame_seq #(
	parameter int unsigned IFG_BYTES = 12
) (
	input  logic                    fifo_clk,
	input  logic                    sys_rst,
	input  logic                    frame_ready,
	input  udp_tx_pkg::payload_len_t payload_words,
	input  udp_tx_pkg::pixel_word_t fifo_data,
	input  logic                    fifo_empty,
	output logic                    fifo_rd_en,
	output udp_tx_pkg::byte_t       txd,
	output logic                    tx_en,
	output logic                    frame_start,
	output udp_tx_pkg::word16_t     ip_total_len,
	output udp_tx_pkg::word16_t     udp_len,
	output udp_tx_pkg::hdr_idx_t    hdr_idx,
	input  udp_tx_pkg::byte_t       hdr_byte,
	output logic                    crc_init,
	output logic                    crc_en,
	output udp_tx_pkg::byte_t       crc_byte,
	output logic [1:0]              fcs_idx,
	input  udp_tx_pkg::byte_t       fcs_byte
);

	udp_tx_pkg::tx_state_e    state;
	logic [15:0]              byte_cnt;
	udp_tx_pkg::payload_len_t words_q;
	udp_tx_pkg::word16_t      payload_bytes;
	logic                     start_ok;
	logic                     last_byte;

	assign start_ok = frame_ready & ~fifo_empty;

	// --------------------------------------------------
	// Lengths fixed for the frame
	// --------------------------------------------------
	assign payload_bytes = {4'd0, words_q, 1'b0};
	// The extra byte is the packet type
	assign ip_total_len = udp_tx_pkg::word16_t'(udp_tx_pkg::IP_HDR_LEN
		+ udp_tx_pkg::UDP_HDR_LEN + 1) + payload_bytes;
	assign udp_len = udp_tx_pkg::word16_t'(udp_tx_pkg::UDP_HDR_LEN + 1) + payload_bytes;

	// Checksum is taken on the first preamble byte
	assign frame_start = (state == udp_tx_pkg::ST_PREAMBLE) && (byte_cnt == 16'd0);

	// Last byte of each phase
	// Single-cycle states count as done at once
	always_comb begin
		case (state)
			udp_tx_pkg::ST_PREAMBLE:
				last_byte = byte_cnt == 16'(udp_tx_pkg::PREAMBLE_LEN - 1);
			udp_tx_pkg::ST_HEADER:
				last_byte = byte_cnt == 16'(udp_tx_pkg::HDR_LEN - 1);
			udp_tx_pkg::ST_PAYLOAD:
				last_byte = byte_cnt == payload_bytes - 16'd1;
			udp_tx_pkg::ST_FCS:
				last_byte = byte_cnt == 16'd3;
			udp_tx_pkg::ST_GAP:
				last_byte = byte_cnt == 16'(IFG_BYTES - 1);
			default:
				last_byte = 1'b1;
		endcase
	end

	// --------------------------------------------------
	// State and byte counter
	// --------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= udp_tx_pkg::ST_IDLE;
			byte_cnt <= '0;
			words_q  <= '0;
		end else begin
			byte_cnt <= last_byte ? 16'd0 : byte_cnt + 16'd1;
			case (state)
				udp_tx_pkg::ST_IDLE: begin
					if (start_ok) begin
						words_q <= payload_words;
						state   <= udp_tx_pkg::ST_PREAMBLE;
					end
				end
				udp_tx_pkg::ST_PREAMBLE: begin
					if (last_byte) begin
						state <= udp_tx_pkg::ST_SFD;
					end
				end
				udp_tx_pkg::ST_SFD: begin
					state <= udp_tx_pkg::ST_HEADER;
				end
				udp_tx_pkg::ST_HEADER: begin
					// Empty payload goes straight to the FCS
					if (last_byte) begin
						state <= (words_q == '0) ? udp_tx_pkg::ST_FCS : udp_tx_pkg::ST_PAYLOAD;
					end
				end
				udp_tx_pkg::ST_PAYLOAD: begin
					if (last_byte) begin
						state <= udp_tx_pkg::ST_FCS;
					end
				end
				udp_tx_pkg::ST_FCS: begin
					if (last_byte) begin
						state <= udp_tx_pkg::ST_GAP;
					end
				end
				udp_tx_pkg::ST_GAP: begin
					if (last_byte) begin
						state <= udp_tx_pkg::ST_IDLE;
					end
				end
				default: state <= udp_tx_pkg::ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// Output byte select
	// --------------------------------------------------
	always_comb begin
		txd        = 8'h00;
		tx_en      = 1'b0;
		fifo_rd_en = 1'b0;
		crc_init   = 1'b0;
		crc_en     = 1'b0;
		case (state)
			udp_tx_pkg::ST_PREAMBLE: begin
				txd   = udp_tx_pkg::PREAMBLE_BYTE;
				tx_en = 1'b1;
			end
			udp_tx_pkg::ST_SFD: begin
				txd      = udp_tx_pkg::SFD_BYTE;
				tx_en    = 1'b1;
				crc_init = 1'b1;
			end
			udp_tx_pkg::ST_HEADER: begin
				txd    = hdr_byte;
				tx_en  = 1'b1;
				crc_en = 1'b1;
			end
			udp_tx_pkg::ST_PAYLOAD: begin
				// High byte first and the word pops with the low byte
				txd        = byte_cnt[0] ? fifo_data[7:0] : fifo_data[15:8];
				tx_en      = 1'b1;
				crc_en     = 1'b1;
				fifo_rd_en = byte_cnt[0];
			end
			udp_tx_pkg::ST_FCS: begin
				txd   = fcs_byte;
				tx_en = 1'b1;
			end
			default: ;
		endcase
	end

	assign crc_byte = txd;
	assign hdr_idx  = byte_cnt[5:0];
	assign fcs_idx  = byte_cnt[1:0];

	// Source must keep the FIFO filled for the whole payload
	a_no_read_when_empty: assert property (
		@(posedge fifo_clk) disable iff (sys_rst)
		fifo_rd_en |-> !fifo_empty
	);

	// Gap and the idle cycle after it keep the line quiet
	a_quiet_in_gap: assert property (
		@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> !tx_en [* IFG_BYTES + 1]
	);

endmodule

/* hw/udp_video_tx.sv */
module udp_video_tx #(
	parameter udp_tx_pkg::mac_addr_t SRC_MAC      = 48'h00_23_45_67_89_01,
	parameter udp_tx_pkg::mac_addr_t DST_MAC      = 48'h00_23_45_67_89_02,
	parameter udp_tx_pkg::ip_addr_t  SRC_IP       = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter udp_tx_pkg::ip_addr_t  DST_IP       = {8'd192, 8'd168, 8'd0, 8'd2},
	parameter udp_tx_pkg::word16_t   UDP_SRC_PORT = 16'd12344,
	parameter udp_tx_pkg::word16_t   UDP_DST_PORT = 16'd12345,
	parameter int unsigned           IFG_BYTES    = 12
) (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  logic                     frame_ready,
	input  udp_tx_pkg::payload_len_t payload_words,
	input  udp_tx_pkg::pixel_word_t  fifo_data,
	input  logic                     fifo_empty,
	output logic                     fifo_rd_en,
	output udp_tx_pkg::byte_t        txd,
	output logic                     tx_en
);

	logic                  frame_start;
	udp_tx_pkg::word16_t   ip_total_len;
	udp_tx_pkg::word16_t   udp_len;
	udp_tx_pkg::word16_t   ip_checksum;
	udp_tx_pkg::hdr_idx_t  hdr_idx;
	udp_tx_pkg::byte_t     hdr_byte;
	logic                  crc_init;
	logic                  crc_en;
	udp_tx_pkg::byte_t     crc_byte;
	logic [1:0]            fcs_idx;
	udp_tx_pkg::byte_t     fcs_byte;

	gmii_frame_seq #(
		.IFG_BYTES(IFG_BYTES)
	) u_gmii_frame_seq (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.frame_ready  (frame_ready),
		.payload_words(payload_words),
		.fifo_data    (fifo_data),
		.fifo_empty   (fifo_empty),
		.fifo_rd_en   (fifo_rd_en),
		.txd          (txd),
		.tx_en        (tx_en),
		.frame_start  (frame_start),
		.ip_total_len (ip_total_len),
		.udp_len      (udp_len),
		.hdr_idx      (hdr_idx),
		.hdr_byte     (hdr_byte),
		.crc_init     (crc_init),
		.crc_en       (crc_en),
		.crc_byte     (crc_byte),
		.fcs_idx      (fcs_idx),
		.fcs_byte     (fcs_byte)
	);

	ipv4_checksum #(
		.SRC_IP(SRC_IP),
		.DST_IP(DST_IP)
	) u_ipv4_checksum (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.frame_start (frame_start),
		.ip_total_len(ip_total_len),
		.ip_checksum (ip_checksum)
	);

	udp_header_gen #(
		.SRC_MAC     (SRC_MAC),
		.DST_MAC     (DST_MAC),
		.SRC_IP      (SRC_IP),
		.DST_IP      (DST_IP),
		.UDP_SRC_PORT(UDP_SRC_PORT),
		.UDP_DST_PORT(UDP_DST_PORT)
	) u_udp_header_gen (
		.hdr_idx     (hdr_idx),
		.ip_total_len(ip_total_len),
		.udp_len     (udp_len),
		.ip_checksum (ip_checksum),
		.hdr_byte    (hdr_byte)
	);

	eth_crc32 u_eth_crc32 (
		.fifo_clk(fifo_clk),
		.sys_rst (sys_rst),
		.crc_init(crc_init),
		.crc_en  (crc_en),
		.crc_byte(crc_byte),
		.fcs_idx (fcs_idx),
		.fcs_byte(fcs_byte)
	);

endmodule

/* include/udp_video_tx_tb_cases.svh */
`ifndef UDP_VIDEO_TX_TB_CASES_SVH
`define UDP_VIDEO_TX_TB_CASES_SVH

// --------------------------------------------------
// DUT addresses and ports
// --------------------------------------------------
localparam udp_tx_pkg::mac_addr_t TB_SRC_MAC   = 48'h02_00_5e_10_00_01;
localparam udp_tx_pkg::mac_addr_t TB_DST_MAC   = 48'h02_00_5e_10_00_02;
localparam udp_tx_pkg::ip_addr_t  TB_SRC_IP    = {8'd10, 8'd0, 8'd21, 8'd9};
localparam udp_tx_pkg::ip_addr_t  TB_DST_IP    = {8'd10, 8'd0, 8'd21, 8'd41};
localparam udp_tx_pkg::word16_t   TB_SRC_PORT  = 16'd12344;
localparam udp_tx_pkg::word16_t   TB_DST_PORT  = 16'd12345;
localparam int unsigned           TB_IFG_BYTES = 12;

localparam logic [31:0] TB_SEED = 32'h5a9d_1473;

// One frame per row
typedef struct packed {
	udp_tx_pkg::payload_len_t words;
	// Keep frame_ready up so the next row follows after the gap
	logic                     back_to_back;
	udp_tx_pkg::word16_t      exp_ip_len;
	udp_tx_pkg::word16_t      exp_udp_len;
} tb_case_t;

localparam int TB_NUM_CASES = 5;

// Expected lengths are 29 + 2N and 9 + 2N
localparam tb_case_t TB_CASES [TB_NUM_CASES] = '{
	'{words: 11'd1,   back_to_back: 1'b0, exp_ip_len: 16'd31,   exp_udp_len: 16'd11},
	'{words: 11'd4,   back_to_back: 1'b1, exp_ip_len: 16'd37,   exp_udp_len: 16'd17},
	'{words: 11'd37,  back_to_back: 1'b1, exp_ip_len: 16'd103,  exp_udp_len: 16'd83},
	'{words: 11'd600, back_to_back: 1'b0, exp_ip_len: 16'd1229, exp_udp_len: 16'd1209},
	'{words: 11'd2,   back_to_back: 1'b0, exp_ip_len: 16'd33,   exp_udp_len: 16'd13}
};

`endif

/* verif/udp_video_tx_tb.sv */
module udp_video_tx_tb;

	`include "udp_video_tx_tb_cases.svh"

	localparam int WAIT_LIMIT  = 100;
	localparam int FRAME_LIMIT = 2000;

	logic                     fifo_clk;
	logic                     sys_rst;
	logic                     frame_ready;
	udp_tx_pkg::payload_len_t payload_words;
	udp_tx_pkg::pixel_word_t  fifo_data;
	logic                     fifo_empty;
	logic                     fifo_rd_en;
	udp_tx_pkg::byte_t        txd;
	logic                     tx_en;

	udp_tx_pkg::pixel_word_t fifo_q[$];
	udp_tx_pkg::pixel_word_t all_words[$];
	udp_tx_pkg::byte_t       frame_q[$];
	udp_tx_pkg::byte_t       exp_q[$];
	logic                    pop_pending;
	int                      rd_pulses;
	int                      low_run;
	int                      gap_before;

	udp_video_tx #(
		.SRC_MAC     (TB_SRC_MAC),
		.DST_MAC     (TB_DST_MAC),
		.SRC_IP      (TB_SRC_IP),
		.DST_IP      (TB_DST_IP),
		.UDP_SRC_PORT(TB_SRC_PORT),
		.UDP_DST_PORT(TB_DST_PORT),
		.IFG_BYTES   (TB_IFG_BYTES)
	) u_udp_video_tx (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.frame_ready  (frame_ready),
		.payload_words(payload_words),
		.fifo_data    (fifo_data),
		.fifo_empty   (fifo_empty),
		.fifo_rd_en   (fifo_rd_en),
		.txd          (txd),
		.tx_en        (tx_en)
	);

	task automatic fail_mismatch(input string sig, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		$display("mismatch at time %0t: %s expected 0x%0h got 0x%0h", $time, sig, exp_val,
			got_val);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_plain(input string what);
		$display("error at time %0t: %s", $time, what);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	initial begin
		fifo_clk = 1'b0;
		forever #10 fifo_clk = ~fifo_clk;
	end

	// --------------------------------------------------
	// First-word-fall-through FIFO model
	// --------------------------------------------------
	initial begin
		fifo_data  = '0;
		fifo_empty = 1'b1;
		forever begin
			@(posedge fifo_clk);
			#1;
			if (pop_pending) begin
				if (fifo_q.size() > 0) begin
					void'(fifo_q.pop_front());
				end
				pop_pending = 1'b0;
			end
			fifo_empty = (fifo_q.size() == 0);
			fifo_data  = fifo_empty ? '0 : fifo_q[0];
		end
	end

	// Mid-cycle monitor for pops and the low run before each frame
	always @(negedge fifo_clk) begin
		if (fifo_rd_en) begin
			assert (!fifo_empty)
			else fail_plain("fifo_rd_en was high while the FIFO model was empty");
			pop_pending = 1'b1;
		end
		if (tx_en) begin
			if (low_run > 0) begin
				gap_before = low_run;
			end
			low_run = 0;
		end else begin
			low_run++;
		end
	end

	task automatic check_idle_cycles(input int cycles);
		repeat (cycles) begin
			@(negedge fifo_clk);
			assert (!tx_en) else fail_mismatch("tx_en", 0, tx_en);
			assert (!fifo_rd_en) else fail_mismatch("fifo_rd_en", 0, fifo_rd_en);
		end
	endtask

	task automatic wait_frame_start();
		int guard;
		guard = 0;
		while (!tx_en) begin
			@(negedge fifo_clk);
			guard++;
			assert (guard < WAIT_LIMIT) else fail_plain("tx_en never rose for the next frame");
		end
	endtask

	// Starts on the first high tx_en cycle
	// Next inputs are driven once the frame is running
	task automatic collect_frame(input logic keep_ready, input udp_tx_pkg::payload_len_t next_n);
		int guard;
		guard     = 0;
		rd_pulses = 0;
		frame_q.delete();
		while (tx_en) begin
			frame_q.push_back(txd);
			if (fifo_rd_en) begin
				rd_pulses++;
			end
			if (frame_q.size() == 1) begin
				@(posedge fifo_clk);
				#1;
				frame_ready   = keep_ready;
				payload_words = next_n;
			end
			guard++;
			assert (guard < FRAME_LIMIT) else fail_plain("tx_en stayed high too long");
			@(negedge fifo_clk);
		end
	endtask

	// --------------------------------------------------
	// Reference frame from the protocol rules
	// --------------------------------------------------
	task automatic build_expected(input udp_tx_pkg::payload_len_t n, input int base);
		udp_tx_pkg::byte_t   hdr[43];
		udp_tx_pkg::word16_t ip_len;
		udp_tx_pkg::word16_t u_len;
		logic [31:0]         sum;
		logic [31:0]         crc;
		logic                fb;
		int                  i;
		int                  j;
		ip_len = 16'd29 + 16'(2 * n);
		u_len  = 16'd9 + 16'(2 * n);
		for (i = 0; i < 6; i++) begin
			hdr[i]     = TB_DST_MAC[47 - 8 * i -: 8];
			hdr[6 + i] = TB_SRC_MAC[47 - 8 * i -: 8];
		end
		hdr[12] = 8'h08;
		hdr[13] = 8'h00;
		hdr[14] = 8'h45;
		hdr[15] = 8'h00;
		hdr[16] = ip_len[15:8];
		hdr[17] = ip_len[7:0];
		hdr[18] = 8'h00;
		hdr[19] = 8'h00;
		// DF set, TTL 64, protocol UDP
		hdr[20] = 8'h40;
		hdr[21] = 8'h00;
		hdr[22] = 8'h40;
		hdr[23] = 8'h11;
		hdr[24] = 8'h00;
		hdr[25] = 8'h00;
		for (i = 0; i < 4; i++) begin
			hdr[26 + i] = TB_SRC_IP[31 - 8 * i -: 8];
			hdr[30 + i] = TB_DST_IP[31 - 8 * i -: 8];
		end
		hdr[34] = TB_SRC_PORT[15:8];
		hdr[35] = TB_SRC_PORT[7:0];
		hdr[36] = TB_DST_PORT[15:8];
		hdr[37] = TB_DST_PORT[7:0];
		hdr[38] = u_len[15:8];
		hdr[39] = u_len[7:0];
		hdr[40] = 8'h00;
		hdr[41] = 8'h00;
		hdr[42] = 8'h00;
		// Ones'-complement sum of the ten IP header words
		sum = 0;
		for (i = 14; i < 34; i += 2) begin
			sum = sum + {16'd0, hdr[i], hdr[i + 1]};
		end
		while (sum[31:16] != 0) begin
			sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
		end
		hdr[24] = ~sum[15:8];
		hdr[25] = ~sum[7:0];
		exp_q.delete();
		repeat (7) exp_q.push_back(8'h55);
		exp_q.push_back(8'hd5);
		for (i = 0; i < 43; i++) begin
			exp_q.push_back(hdr[i]);
		end
		for (i = 0; i < n; i++) begin
			exp_q.push_back(all_words[base + i][15:8]);
			exp_q.push_back(all_words[base + i][7:0]);
		end
		// Reflected CRC-32 one bit at a time with the LSB of each byte first
		crc = 32'hffff_ffff;
		for (i = 8; i < exp_q.size(); i++) begin
			for (j = 0; j < 8; j++) begin
				fb  = crc[0] ^ exp_q[i][j];
				crc = crc >> 1;
				if (fb) begin
					crc = crc ^ 32'hedb8_8320;
				end
			end
		end
		crc = ~crc;
		for (i = 0; i < 4; i++) begin
			exp_q.push_back(crc[8 * i +: 8]);
		end
	endtask

	task automatic check_frame(input int r);
		int          i;
		int          n_bytes;
		logic [31:0] got_fcs;
		logic [31:0] exp_fcs;
		n_bytes = frame_q.size();
		assert (n_bytes == exp_q.size())
		else fail_mismatch("tx_en high cycles", exp_q.size(), n_bytes);
		assert (rd_pulses == TB_CASES[r].words)
		else fail_mismatch("fifo_rd_en pulses", TB_CASES[r].words, rd_pulses);
		assert ({frame_q[24], frame_q[25]} == TB_CASES[r].exp_ip_len)
		else fail_mismatch("ip_total_len", TB_CASES[r].exp_ip_len, {frame_q[24], frame_q[25]});
		assert ({frame_q[46], frame_q[47]} == TB_CASES[r].exp_udp_len)
		else fail_mismatch("udp_len", TB_CASES[r].exp_udp_len, {frame_q[46], frame_q[47]});
		assert ({frame_q[32], frame_q[33]} == {exp_q[32], exp_q[33]})
		else fail_mismatch("ip_checksum", {exp_q[32], exp_q[33]}, {frame_q[32], frame_q[33]});
		got_fcs = {frame_q[n_bytes - 1], frame_q[n_bytes - 2], frame_q[n_bytes - 3],
			frame_q[n_bytes - 4]};
		exp_fcs = {exp_q[n_bytes - 1], exp_q[n_bytes - 2], exp_q[n_bytes - 3],
			exp_q[n_bytes - 4]};
		assert (got_fcs == exp_fcs) else fail_mismatch("fcs", exp_fcs, got_fcs);
		for (i = 0; i < n_bytes; i++) begin
			assert (frame_q[i] == exp_q[i])
			else fail_mismatch($sformatf("txd byte %0d", i), exp_q[i], frame_q[i]);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int                       r;
		int                       i;
		int                       base;
		udp_tx_pkg::payload_len_t next_n;
		sys_rst       = 1'b1;
		frame_ready   = 1'b0;
		payload_words = '0;
		pop_pending   = 1'b0;
		low_run       = 0;
		gap_before    = 0;
		void'($urandom(TB_SEED));
		repeat (5) @(posedge fifo_clk);
		#1;
		sys_rst = 1'b0;
		@(negedge fifo_clk);
		assert (txd == 8'h00) else fail_mismatch("txd", 0, txd);

		// Ready without data, then data without ready
		@(posedge fifo_clk);
		#1;
		frame_ready = 1'b1;
		check_idle_cycles(10);
		@(posedge fifo_clk);
		#1;
		frame_ready = 1'b0;
		for (r = 0; r < TB_NUM_CASES; r++) begin
			for (i = 0; i < TB_CASES[r].words; i++) begin
				all_words.push_back(udp_tx_pkg::pixel_word_t'($urandom));
			end
		end
		fifo_q = all_words;
		check_idle_cycles(10);

		base = 0;
		for (r = 0; r < TB_NUM_CASES; r++) begin
			if (r == 0 || !TB_CASES[r - 1].back_to_back) begin
				@(posedge fifo_clk);
				#1;
				payload_words = TB_CASES[r].words;
				frame_ready   = 1'b1;
			end
			wait_frame_start();
			next_n = (r + 1 < TB_NUM_CASES) ? TB_CASES[r + 1].words : '0;
			collect_frame(TB_CASES[r].back_to_back, next_n);
			if (r > 0 && TB_CASES[r - 1].back_to_back) begin
				assert (gap_before == TB_IFG_BYTES + 1)
				else fail_mismatch("tx_en low cycles between frames", TB_IFG_BYTES + 1,
					gap_before);
			end
			build_expected(TB_CASES[r].words, base);
			check_frame(r);
			base += TB_CASES[r].words;
		end
		check_idle_cycles(TB_IFG_BYTES + 4);

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
hw/udp_tx_pkg.sv
hw/ipv4_checksum.sv
hw/eth_crc32.sv
hw/udp_header_gen.sv
hw/gmii_frame_seq.sv
hw/udp_video_tx.sv
verif/udp_video_tx_tb.sv
